//--- rtl/bnn_cfg.svh
`ifndef BNN_CFG_SVH
`define BNN_CFG_SVH

// network shape
`define BNN_FEAT_CNT    4
`define BNN_FEAT_BITS   4
`define BNN_HIDDEN_CNT  8
`define BNN_CLASS_CNT   4
`define BNN_CLASS_BITS  2
`define BNN_SCORE_BITS  4

// hidden weights, 4 bits per neuron with neuron 0 in the low nibble, 1 is +1 and 0 is -1
`define BNN_HIDDEN_W    32'hA5C3_0F69

// output weights, one byte per class with class 0 in the low byte
`define BNN_OUT_W       32'h815F_F33C

`endif

//--- rtl/bnn_pkg.sv
`default_nettype none

`include "bnn_cfg.svh"

package bnn_pkg;

  typedef logic [`BNN_FEAT_CNT*`BNN_FEAT_BITS-1:0] feat_vec_t;
  typedef logic [`BNN_HIDDEN_CNT-1:0] hidden_t;
  typedef logic [`BNN_CLASS_BITS-1:0] class_t;
  typedef logic [`BNN_SCORE_BITS-1:0] score_t;

  typedef enum logic [1:0] {
    HID_IDLE,
    HID_RUN,
    HID_HOLD
  } hid_state_t;

  typedef enum logic [1:0] {
    VOTE_IDLE,
    VOTE_SCAN,
    VOTE_EMIT
  } vote_state_t;

endpackage

`default_nettype wire

//--- rtl/hidden_layer_serial.sv
`timescale 1ns/1ns
`default_nettype none

`include "bnn_cfg.svh"

module hidden_layer_serial (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     start,
  input  wire bnn_pkg::feat_vec_t features,
  input  wire                     full,
  output logic                    busy,
  output logic                    push,
  output bnn_pkg::hidden_t        push_data
);

  localparam int FEAT_CNT   = `BNN_FEAT_CNT;
  localparam int FEAT_BITS  = `BNN_FEAT_BITS;
  localparam int HIDDEN_CNT = `BNN_HIDDEN_CNT;
  localparam int NEG_W      = $clog2(FEAT_CNT + 1);
  localparam int SUM_W      = FEAT_BITS + $clog2(FEAT_CNT) + 2;

  localparam logic [HIDDEN_CNT*FEAT_CNT-1:0] HID_W = `BNN_HIDDEN_W;

  // number of -1 weights per neuron, folded into the sum as the +1 of each negation
  function automatic logic [HIDDEN_CNT*NEG_W-1:0] neg_table();
    logic [HIDDEN_CNT*NEG_W-1:0] tbl;
    int cnt;
    tbl = '0;
    for (int n = 0; n < HIDDEN_CNT; n++) begin
      cnt = 0;
      for (int i = 0; i < FEAT_CNT; i++) begin
        if (!HID_W[n*FEAT_CNT+i]) begin
          cnt++;
        end
      end
      tbl[n*NEG_W +: NEG_W] = NEG_W'(cnt);
    end
    return tbl;
  endfunction

  localparam logic [HIDDEN_CNT*NEG_W-1:0] NEG_TBL = neg_table();

  bnn_pkg::hid_state_t   state;
  logic [HIDDEN_CNT-1:0] token;
  bnn_pkg::feat_vec_t    feat_q;
  bnn_pkg::hidden_t      hid_q;
  logic [FEAT_CNT-1:0]   sel_w;
  logic [NEG_W-1:0]      sel_neg;
  logic [SUM_W-1:0]      term;
  logic [SUM_W-1:0]      sum;
  logic                  neuron_bit;

  // the token picks exactly one neuron's weights and its negative count
  always_comb begin
    sel_w   = '0;
    sel_neg = '0;
    for (int n = 0; n < HIDDEN_CNT; n++) begin
      if (token[n]) begin
        sel_w   = sel_w | HID_W[n*FEAT_CNT +: FEAT_CNT];
        sel_neg = sel_neg | NEG_TBL[n*NEG_W +: NEG_W];
      end
    end
  end

  // -f is formed as ~f here, the missing ones come in through sel_neg
  always_comb begin
    sum  = SUM_W'(sel_neg);
    term = '0;
    for (int i = 0; i < FEAT_CNT; i++) begin
      term = SUM_W'(feat_q[i*FEAT_BITS +: FEAT_BITS]);
      if (!sel_w[i]) begin
        term = ~term;
      end
      sum = sum + term;
    end
  end

  assign neuron_bit = ~sum[SUM_W-1];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= bnn_pkg::HID_IDLE;
      token <= '0;
    end else begin
      case (state)
        bnn_pkg::HID_IDLE: begin
          if (start) begin
            state <= bnn_pkg::HID_RUN;
            token <= HIDDEN_CNT'(1);
          end
        end
        bnn_pkg::HID_RUN: begin
          token <= token << 1;
          if (token[HIDDEN_CNT-1]) begin
            state <= bnn_pkg::HID_HOLD;
          end
        end
        bnn_pkg::HID_HOLD: begin
          if (!full) begin
            state <= bnn_pkg::HID_IDLE;
          end
        end
        default: state <= bnn_pkg::HID_IDLE;
      endcase
    end
  end

  // neuron 0 enters first at the top and ends up in bit 0
  always_ff @(posedge clk) begin
    if (state == bnn_pkg::HID_IDLE && start) begin
      feat_q <= features;
    end
    if (state == bnn_pkg::HID_RUN) begin
      hid_q <= {neuron_bit, hid_q[HIDDEN_CNT-1:1]};
    end
  end

  assign busy      = (state != bnn_pkg::HID_IDLE);
  assign push      = (state == bnn_pkg::HID_HOLD) && !full;
  assign push_data = hid_q;

endmodule

`default_nettype wire

//--- rtl/hidden_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module hidden_fifo (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   push,
  input  wire bnn_pkg::hidden_t push_data,
  input  wire                   pop,
  output bnn_pkg::hidden_t      pop_data,
  output logic                  full,
  output logic                  empty
);

  localparam int DEPTH = 2;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  bnn_pkg::hidden_t mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // simultaneous push and pop leaves the occupancy unchanged
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  assign pop_data = mem[rd_ptr];
  assign full     = (count == CNT_W'(DEPTH));
  assign empty    = (count == '0);

endmodule

`default_nettype wire

//--- rtl/output_layer_vote.sv
`timescale 1ns/1ns
`default_nettype none

`include "bnn_cfg.svh"

module output_layer_vote (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   empty,
  input  wire bnn_pkg::hidden_t pop_data,
  output logic                  pop,
  output logic                  result_valid,
  output bnn_pkg::class_t       result_class,
  output bnn_pkg::score_t       result_score
);

  localparam int HIDDEN_CNT = `BNN_HIDDEN_CNT;
  localparam int CLASS_CNT  = `BNN_CLASS_CNT;

  localparam logic [CLASS_CNT*HIDDEN_CNT-1:0] OUT_W = `BNN_OUT_W;
  localparam bnn_pkg::class_t LAST_CLS = bnn_pkg::class_t'(CLASS_CNT - 1);

  bnn_pkg::vote_state_t state;
  bnn_pkg::class_t      cls;
  bnn_pkg::hidden_t     hid_q;
  bnn_pkg::hidden_t     agree;
  bnn_pkg::score_t      score;
  bnn_pkg::score_t      best_score;
  bnn_pkg::class_t      best_cls;
  bnn_pkg::score_t      next_score;
  bnn_pkg::class_t      next_cls;
  logic                 better;

  // a vote is a matching bit between the hidden vector and the class weights
  always_comb begin
    agree = ~(hid_q ^ OUT_W[cls*HIDDEN_CNT +: HIDDEN_CNT]);
    score = '0;
    for (int b = 0; b < HIDDEN_CNT; b++) begin
      score = score + bnn_pkg::score_t'(agree[b]);
    end
  end

  // strictly greater only, so an equal score keeps the earlier class
  assign better     = (cls == '0) || (score > best_score);
  assign next_score = better ? score : best_score;
  assign next_cls   = better ? cls : best_cls;

  assign pop = ((state == bnn_pkg::VOTE_IDLE) || (state == bnn_pkg::VOTE_EMIT)) && !empty;
  assign result_valid = (state == bnn_pkg::VOTE_EMIT);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state        <= bnn_pkg::VOTE_IDLE;
      cls          <= '0;
      best_score   <= '0;
      best_cls     <= '0;
      result_class <= '0;
      result_score <= '0;
    end else begin
      case (state)
        bnn_pkg::VOTE_IDLE, bnn_pkg::VOTE_EMIT: begin
          cls <= '0;
          if (pop) begin
            state <= bnn_pkg::VOTE_SCAN;
          end else begin
            state <= bnn_pkg::VOTE_IDLE;
          end
        end
        bnn_pkg::VOTE_SCAN: begin
          best_score <= next_score;
          best_cls   <= next_cls;
          cls        <= cls + 1'b1;
          if (cls == LAST_CLS) begin
            state        <= bnn_pkg::VOTE_EMIT;
            result_class <= next_cls;
            result_score <= next_score;
          end
        end
        default: state <= bnn_pkg::VOTE_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      hid_q <= pop_data;
    end
  end

endmodule

`default_nettype wire

//--- rtl/bnn_classifier_top.sv
`timescale 1ns/1ns
`default_nettype none

module bnn_classifier_top (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     start,
  input  wire bnn_pkg::feat_vec_t features,
  output wire                     busy,
  output wire                     result_valid,
  output wire bnn_pkg::class_t    result_class,
  output wire bnn_pkg::score_t    result_score
);

  wire                   push;
  wire bnn_pkg::hidden_t push_data;
  wire                   full;
  wire                   pop;
  wire bnn_pkg::hidden_t pop_data;
  wire                   empty;

  hidden_layer_serial producer0 (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .features  (features),
    .full      (full),
    .busy      (busy),
    .push      (push),
    .push_data (push_data)
  );

  // the FIFO lets the next sample run while the previous one is still voting
  hidden_fifo fifo0 (
    .clk       (clk),
    .rst       (rst),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .pop_data  (pop_data),
    .full      (full),
    .empty     (empty)
  );

  output_layer_vote consumer0 (
    .clk          (clk),
    .rst          (rst),
    .empty        (empty),
    .pop_data     (pop_data),
    .pop          (pop),
    .result_valid (result_valid),
    .result_class (result_class),
    .result_score (result_score)
  );

endmodule

`default_nettype wire

//--- bench/bnn_classifier_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "bnn_cfg.svh"

module bnn_classifier_tb;

  localparam int IDLE_LIMIT   = 40;
  localparam int RESULT_LIMIT = 100;

  logic                     clk = 1'b0;
  logic                     rst;
  logic                     start;
  bnn_pkg::feat_vec_t       features;
  wire                      busy;
  wire                      result_valid;
  wire bnn_pkg::class_t     result_class;
  wire bnn_pkg::score_t     result_score;

  bnn_pkg::feat_vec_t trace_feat [$];
  bnn_pkg::class_t    trace_class [$];
  bnn_pkg::score_t    trace_score [$];
  bnn_pkg::class_t    exp_class_q [$];
  bnn_pkg::score_t    exp_score_q [$];

  int start_count   = 0;
  int result_count  = 0;
  int result_errors = 0;
  int level_errors  = 0;
  int stray_results = 0;
  int fail_count    = 0;
  bit timed_out     = 1'b0;

  bnn_classifier_top dut0 (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .features     (features),
    .busy         (busy),
    .result_valid (result_valid),
    .result_class (result_class),
    .result_score (result_score)
  );

  always #20 clk = ~clk;

  // the reference neuron takes the plain signed sum of +-f and sets its bit when it is not negative
  function automatic bnn_pkg::hidden_t model_hidden(input bnn_pkg::feat_vec_t f);
    logic [`BNN_HIDDEN_CNT*`BNN_FEAT_CNT-1:0] w;
    bnn_pkg::hidden_t h;
    int sum;
    int x;
    w = `BNN_HIDDEN_W;
    h = '0;
    for (int n = 0; n < `BNN_HIDDEN_CNT; n++) begin
      sum = 0;
      for (int i = 0; i < `BNN_FEAT_CNT; i++) begin
        x = int'(f[i*`BNN_FEAT_BITS +: `BNN_FEAT_BITS]);
        sum = w[n*`BNN_FEAT_CNT + i] ? sum + x : sum - x;
      end
      h[n] = (sum >= 0);
    end
    return h;
  endfunction

  task automatic model_classify(input bnn_pkg::feat_vec_t f, output bnn_pkg::class_t c,
                                output bnn_pkg::score_t s);
    logic [`BNN_CLASS_CNT*`BNN_HIDDEN_CNT-1:0] w;
    bnn_pkg::hidden_t h;
    int votes;
    int best;
    w = `BNN_OUT_W;
    h = model_hidden(f);
    best = -1;
    c = '0;
    for (int k = 0; k < `BNN_CLASS_CNT; k++) begin
      votes = 0;
      for (int b = 0; b < `BNN_HIDDEN_CNT; b++) begin
        if (h[b] == w[k*`BNN_HIDDEN_CNT + b]) begin
          votes++;
        end
      end
      if (votes > best) begin
        best = votes;
        c = bnn_pkg::class_t'(k);
      end
    end
    s = bnn_pkg::score_t'(best);
  endtask

  task automatic check_class(input bnn_pkg::class_t got, input bnn_pkg::class_t exp,
                             input int idx);
    if (got !== exp) begin
      result_errors++;
      $display("error at %0t ns: result %0d class is %0d, expected %0d", $time, idx, got, exp);
    end
  endtask

  task automatic check_score(input bnn_pkg::score_t got, input bnn_pkg::score_t exp,
                             input int idx);
    if (got !== exp) begin
      result_errors++;
      $display("error at %0t ns: result %0d score is %0d, expected %0d", $time, idx, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      level_errors++;
      $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("value errors: %0d, other failures: %0d",
             result_errors + level_errors, fail_count + stray_results);
    if (result_errors + level_errors + fail_count + stray_results == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  task automatic load_trace();
    int fd;
    int n;
    int f0, f1, f2, f3, c, s;
    string line;
    bnn_pkg::class_t mc;
    bnn_pkg::score_t ms;
    fd = $fopen("bench/bnn_trace.txt", "r");
    if (fd == 0) begin
      fail_count++;
      $display("could not open bench/bnn_trace.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %d %d", f0, f1, f2, f3, c, s);
          if (n == 6) begin
            trace_feat.push_back(bnn_pkg::feat_vec_t'({f3[3:0], f2[3:0], f1[3:0], f0[3:0]}));
            trace_class.push_back(bnn_pkg::class_t'(c));
            trace_score.push_back(bnn_pkg::score_t'(s));
            model_classify(trace_feat[$], mc, ms);
            if (mc != trace_class[$] || ms != trace_score[$]) begin
              fail_count++;
              $display("trace sample %0d lists %0d and %0d but the model gives %0d and %0d",
                       trace_feat.size() - 1, c, s, mc, ms);
            end
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // all main-process waits sit 2 ns after a rising edge
  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (!timed_out && busy && cycles < IDLE_LIMIT) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (!timed_out && busy) begin
      fail_count++;
      timed_out = 1'b1;
      $display("timeout: busy still high after %0d cycles at %0t ns", cycles, $time);
    end
  endtask

  task automatic wait_results();
    int cycles;
    cycles = 0;
    while (!timed_out && result_count < start_count && cycles < RESULT_LIMIT) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (!timed_out && result_count < start_count) begin
      fail_count++;
      timed_out = 1'b1;
      $display("timeout: %0d of %0d results arrived after %0d cycles",
               result_count, start_count, cycles);
    end
  endtask

  // busy seen now is what the DUT samples at the next edge
  task automatic pulse_start(input int idx, output logic accepted);
    accepted = !busy;
    features = trace_feat[idx];
    start = 1'b1;
    if (accepted) begin
      start_count++;
      exp_class_q.push_back(trace_class[idx]);
      exp_score_q.push_back(trace_score[idx]);
    end
    @(posedge clk);
    #2;
    start = 1'b0;
  endtask

  always @(negedge clk) begin
    if (!rst && result_valid) begin
      if (result_count >= exp_class_q.size()) begin
        stray_results++;
        $display("result_valid pulsed at %0t ns with no sample outstanding", $time);
      end else begin
        check_class(result_class, exp_class_q[result_count], result_count);
        check_score(result_score, exp_score_q[result_count], result_count);
      end
      result_count++;
    end
  end

  initial begin
    logic accepted;
    rst = 1'b1;
    start = 1'b0;
    features = '0;
    load_trace();
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;

    repeat (6) begin
      check_bit(busy, 1'b0, "busy after reset");
      check_bit(result_valid, 1'b0, "result_valid after reset");
      @(posedge clk);
      #2;
    end

    if (trace_feat.size() < 2) begin
      fail_count++;
      $display("trace holds too few samples");
    end else begin
      // one sample at a time
      for (int i = 0; i < trace_feat.size() && !timed_out; i++) begin
        wait_idle();
        pulse_start(i, accepted);
        wait_results();
      end

      // the next start goes in as soon as busy falls
      for (int i = 0; i < trace_feat.size() && !timed_out; i++) begin
        wait_idle();
        pulse_start(i, accepted);
      end
      wait_results();

      // a second start in the middle of a run must be dropped
      wait_idle();
      pulse_start(0, accepted);
      repeat (3) @(posedge clk);
      #2;
      pulse_start(1, accepted);
      check_bit(accepted, 1'b0, "start taken while busy");
      wait_idle();
      wait_results();
      repeat (12) @(posedge clk);
      #2;

      if (result_count != start_count) begin
        fail_count++;
        $display("saw %0d result pulses for %0d accepted starts", result_count, start_count);
      end
    end
    finish_run();
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+rtl
rtl/bnn_pkg.sv
rtl/hidden_layer_serial.sv
rtl/hidden_fifo.sv
rtl/output_layer_vote.sv
rtl/bnn_classifier_top.sv
bench/bnn_classifier_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the classifier testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -f project.f --top-module bnn_classifier_tb -o bnn_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/bnn_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" "$LOG"; then
  echo "simulation FAILED"
  exit 1
fi

echo "simulation passed"
exit 0

//--- bench/bnn_trace.txt
# columns: f0 f1 f2 f3 as hex features, then expected class and expected score in decimal
# expected values follow the sign rule, the XNOR popcount vote and the lower-index tie rule
0 0 0 0 1 6
f f f f 1 7
f 0 0 0 2 6
0 f 0 0 0 4
0 0 f 0 0 4
0 0 0 f 3 6
1 2 3 4 1 5
4 3 2 1 2 7
3 3 0 1 3 6
3 0 1 3 0 4
2 2 1 0 2 6
0 1 1 1 0 4
5 2 2 5 1 6
7 2 7 2 1 6
1 0 2 1 1 5
9 4 3 6 2 6
0 0 f f 1 6
